//--- design/exu_alu.sv
module exu_alu (
    input  exu_op_pkg::exu_op_e op,
    input  logic                use_imm,
    input  logic [31:0]         rs1_d,
    input  logic [31:0]         rs2_d,
    input  logic [31:0]         imm,
    input  logic [31:0]         pc,
    output logic [31:0]         result,
    output logic                taken
);
    import exu_op_pkg::*;

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    logic [31:0] diff;
    logic        lt_s;
    logic        lt_u;

    // ------------------------------
    // operand selection
    // ------------------------------
    always_comb begin
        if (op == OP_LUI) begin
            a = 32'd0;
            b = imm;
        end else if (op == OP_AUIPC) begin
            a = pc;
            b = imm;
        end else if (is_load(op) || is_store(op)) begin
            a = rs1_d;
            b = imm;
        end else if (op == OP_JAL || op == OP_JALR) begin
            // link value
            a = pc;
            b = 32'd4;
        end else if (is_branch(op)) begin
            a = rs1_d;
            b = rs2_d;
        end else begin
            a = rs1_d;
            b = use_imm ? imm : rs2_d;
        end
    end

    assign sum  = a + b;
    assign diff = a - b;
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    // ------------------------------
    // result
    // ------------------------------
    always_comb begin
        case (op)
            OP_SUB:  result = diff;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = a << b[4:0];
            OP_SRL:  result = a >> b[4:0];
            OP_SRA:  result = $signed(a) >>> b[4:0];
            OP_SLT:  result = {31'd0, lt_s};
            OP_SLTU: result = {31'd0, lt_u};
            default: result = is_branch(op) ? diff : sum;
        endcase
    end

    // branch condition
    always_comb begin
        case (op)
            OP_BEQ:  taken = (diff == 32'd0);
            OP_BNE:  taken = (diff != 32'd0);
            OP_BLT:  taken = lt_s;
            OP_BGE:  taken = !lt_s;
            OP_BLTU: taken = lt_u;
            OP_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- design/exu_bus_pkg.sv
package exu_bus_pkg;

    import exu_op_pkg::*;

    // access width on the memory side
    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } mem_size_e;

    // load/store controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_DONE
    } lsu_state_e;

    function automatic mem_size_e op_size(exu_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return SZ_BYTE;
            OP_LH, OP_LHU, OP_SH: return SZ_HALF;
            default:              return SZ_WORD;
        endcase
    endfunction

endpackage

//--- design/exu_ctrl_fsm.sv
module exu_ctrl_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  exu_op_pkg::exu_op_e op,
    input  logic                pready,
    input  logic                pslverr,
    input  logic                expired,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic                ready,
    output logic                err,
    output logic                capture_en,
    output logic                abort,
    output logic                timer_run,
    output logic                timer_clr
);
    import exu_op_pkg::*;
    import exu_bus_pkg::*;

    lsu_state_e state;
    lsu_state_e state_nxt;
    logic       mem_op;
    logic       in_access;

    assign mem_op    = is_load(op) || is_store(op);
    assign in_access = (state == ST_ACCESS);

    // ------------------------------
    // state register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (valid) begin
                    state_nxt = mem_op ? ST_SETUP : ST_DONE;
                end
            end
            ST_SETUP:  state_nxt = ST_ACCESS;
            ST_ACCESS: begin
                // timeout wins over a late pready
                if (expired || pready) begin
                    state_nxt = ST_DONE;
                end
            end
            default:   state_nxt = ST_IDLE;
        endcase
    end

    // error flag, reported with ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err <= 1'b0;
        end else if (state == ST_IDLE) begin
            err <= 1'b0;
        end else if (in_access && expired) begin
            err <= 1'b1;
        end else if (in_access && pready) begin
            err <= pslverr;
        end
    end

    // ------------------------------
    // apb control and handshakes
    // ------------------------------
    // psel drops as soon as the timer expires
    assign psel    = (state == ST_SETUP) || (in_access && !expired);
    assign penable = in_access && !expired;
    assign pwrite  = psel && is_store(op);

    assign ready      = (state == ST_DONE);
    assign capture_en = in_access && !expired && pready && is_load(op);
    assign abort      = in_access && expired;

    // count only unanswered access cycles
    assign timer_run = in_access && !pready && !expired;
    assign timer_clr = !in_access;

endmodule

//--- design/exu_lsu_align.sv
module exu_lsu_align (
    input  logic                clk,
    input  logic                rst_n,
    input  exu_op_pkg::exu_op_e op,
    input  logic [1:0]          addr_lo,
    input  logic [31:0]         rs2_d,
    input  logic [31:0]         prdata,
    input  logic                capture_en,
    input  logic                abort,
    output logic [31:0]         pwdata,
    output logic [3:0]          pstrb,
    output logic [31:0]         load_d
);
    import exu_op_pkg::*;
    import exu_bus_pkg::*;

    mem_size_e   size;
    logic [4:0]  lane_sh;
    logic [31:0] rdata_q;
    logic [31:0] lane;
    logic        sext;

    assign size    = op_size(op);
    assign lane_sh = {addr_lo, 3'b000};

    // ------------------------------
    // store side
    // ------------------------------
    assign pwdata = rs2_d << lane_sh;

    always_comb begin
        if (!is_store(op)) begin
            // reads carry no strobes
            pstrb = 4'b0000;
        end else begin
            case (size)
                SZ_BYTE: pstrb = 4'b0001 << addr_lo;
                SZ_HALF: pstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
                default: pstrb = 4'b1111;
            endcase
        end
    end

    // ------------------------------
    // load side
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= 32'd0;
        end else if (abort) begin
            rdata_q <= 32'd0;
        end else if (capture_en) begin
            rdata_q <= prdata;
        end
    end

    assign lane = rdata_q >> lane_sh;
    assign sext = (op == OP_LB) || (op == OP_LH);

    always_comb begin
        case (size)
            SZ_BYTE: load_d = {{24{lane[7] & sext}}, lane[7:0]};
            SZ_HALF: load_d = {{16{lane[15] & sext}}, lane[15:0]};
            default: load_d = lane;
        endcase
    end

endmodule

//--- design/exu_next_pc.sv
module exu_next_pc (
    input  exu_op_pkg::exu_op_e op,
    input  logic                taken,
    input  logic [31:0]         rs1_d,
    input  logic [31:0]         imm,
    input  logic [31:0]         pc,
    output logic [31:0]         dnpc
);
    import exu_op_pkg::*;

    logic [31:0] ina;
    logic [31:0] inb;
    logic [31:0] pc_sum;

    // adder operands
    always_comb begin
        if (op == OP_JALR) begin
            ina = rs1_d;
            inb = imm;
        end else if (op == OP_JAL || (is_branch(op) && taken)) begin
            ina = pc;
            inb = imm;
        end else begin
            // sequential
            ina = pc;
            inb = 32'd4;
        end
    end

    // separate from the alu adder
    assign pc_sum = ina + inb;

    // jalr target has bit 0 cleared
    assign dnpc = (op == OP_JALR) ? {pc_sum[31:1], 1'b0} : pc_sum;

endmodule

//--- design/exu_op_pkg.sv
package exu_op_pkg;

    // ------------------------------
    // decoded opcode
    // ------------------------------
    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
        OP_SLT, OP_SLTU, OP_LUI, OP_AUIPC,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW
    } exu_op_e;

    // ------------------------------
    // opcode class helpers
    // ------------------------------
    function automatic logic is_load(exu_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic is_store(exu_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // conditional branches only, jumps are separate
    function automatic logic is_branch(exu_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

endpackage

//--- design/exu_top.sv
module exu_top #(
    parameter int MAX_WAIT = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    // request side
    input  logic                valid,
    input  exu_op_pkg::exu_op_e op,
    input  logic                use_imm,
    input  logic [31:0]         rs1_d,
    input  logic [31:0]         rs2_d,
    input  logic [31:0]         imm,
    input  logic [31:0]         pc,
    output logic                ready,
    output logic [31:0]         rd_d,
    output logic [31:0]         dnpc,
    output logic                err,
    // apb master
    output logic [31:0]         paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [31:0]         pwdata,
    output logic [3:0]          pstrb,
    input  logic [31:0]         prdata,
    input  logic                pready,
    input  logic                pslverr
);
    import exu_op_pkg::*;

    logic [31:0] result;
    logic        taken;
    logic [31:0] load_d;
    logic        capture_en;
    logic        abort;
    logic        timer_run;
    logic        timer_clr;
    logic        expired;

    // ------------------------------
    // datapath
    // ------------------------------
    exu_alu u_alu (
        .op      (op),
        .use_imm (use_imm),
        .rs1_d   (rs1_d),
        .rs2_d   (rs2_d),
        .imm     (imm),
        .pc      (pc),
        .result  (result),
        .taken   (taken)
    );

    exu_next_pc u_next_pc (
        .op    (op),
        .taken (taken),
        .rs1_d (rs1_d),
        .imm   (imm),
        .pc    (pc),
        .dnpc  (dnpc)
    );

    exu_lsu_align u_lsu_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .addr_lo    (result[1:0]),
        .rs2_d      (rs2_d),
        .prdata     (prdata),
        .capture_en (capture_en),
        .abort      (abort),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .load_d     (load_d)
    );

    // ------------------------------
    // control
    // ------------------------------
    exu_ctrl_fsm u_ctrl_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (valid),
        .op         (op),
        .pready     (pready),
        .pslverr    (pslverr),
        .expired    (expired),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .ready      (ready),
        .err        (err),
        .capture_en (capture_en),
        .abort      (abort),
        .timer_run  (timer_run),
        .timer_clr  (timer_clr)
    );

    exu_wait_timer #(
        .MAX_WAIT (MAX_WAIT)
    ) u_wait_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (timer_run),
        .clr     (timer_clr),
        .expired (expired)
    );

    // word-aligned bus address
    assign paddr = {result[31:2], 2'b00};

    // an aborted load leaves load_d at zero
    always_comb begin
        if (is_load(op)) begin
            rd_d = load_d;
        end else if (is_store(op) || is_branch(op)) begin
            rd_d = 32'd0;
        end else begin
            rd_d = result;
        end
    end

endmodule

//--- design/exu_wait_timer.sv
module exu_wait_timer #(
    parameter int MAX_WAIT = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic clr,
    output logic expired
);
    localparam int CW = $clog2(MAX_WAIT + 1);

    logic [CW-1:0] count;
    logic          at_max;

    assign at_max = (count == CW'(MAX_WAIT));

    // saturating wait counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clr) begin
            count <= '0;
        end else if (run && !at_max) begin
            count <= count + 1'b1;
        end
    end

    assign expired = at_max;

endmodule

//--- flist.f
design/exu_op_pkg.sv
design/exu_bus_pkg.sv
design/exu_alu.sv
design/exu_next_pc.sv
design/exu_lsu_align.sv
design/exu_ctrl_fsm.sv
design/exu_wait_timer.sv
design/exu_top.sv
test/exu_apb_mem.sv
test/exu_tb.sv

//--- test/exu_apb_mem.sv
module exu_apb_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    input  logic [1:0]  wait_cnt,
    input  logic        stall,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [0:255];
    logic [1:0]  waited;
    logic [7:0]  idx;

    // every word differs, pattern built from all index bits
    initial begin
        for (int k = 0; k < 256; k++) begin
            mem[k] = {8'(k) ^ 8'hc3, 8'(k * 7), ~8'(k), 8'(k)};
        end
    end

    assign idx     = paddr[9:2];
    assign prdata  = mem[idx];
    assign pslverr = 1'b0;
    // stall holds pready low for as long as it is set
    assign pready  = psel && penable && !stall && (waited == wait_cnt);

    // access-phase wait counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waited <= 2'd0;
        end else if (psel && penable && !pready) begin
            waited <= (waited == 2'd3) ? waited : waited + 2'd1;
        end else begin
            waited <= 2'd0;
        end
    end

    // byte-strobed write
    always @(posedge clk) begin
        if (psel && penable && pready && pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- test/exu_tb.sv
module exu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import exu_op_pkg::*;
    import exu_bus_pkg::*;

    localparam int MAX_WAIT = 16;
    localparam int N_OPS    = 1 + 200 + 150 + 3 * 150 + 5 * 150 + 11;
    localparam int LIMIT    = N_OPS * (MAX_WAIT + 6) + 50;

    logic        clk;
    logic        rst_n;
    logic        valid;
    exu_op_e     op;
    logic        use_imm;
    logic [31:0] rs1_d, rs2_d, imm, pc;
    logic        ready;
    logic [31:0] rd_d, dnpc;
    logic        err;
    logic [31:0] paddr, pwdata, prdata;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [3:0]  pstrb;
    logic [1:0]  wait_cnt;
    logic        stall;

    // model state and captured responses
    logic [31:0] shadow [0:255];
    logic [31:0] acc_addr, acc_wdata, res_rd, res_dnpc;
    logic [3:0]  acc_strb;
    logic        acc_write, acc_seen, res_err;
    int          lat;
    int          pass_cnt;
    int          fail_cnt;
    int          cycles;

    exu_top #(.MAX_WAIT(MAX_WAIT)) dut0 (.*);
    exu_apb_mem mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= LIMIT) begin
                $display("run stopped after %0d cycles, the DUT stopped answering", cycles);
                $display("Errors found");
                $finish;
            end
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [31:0] sext12(logic [31:0] r);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic logic [31:0] alu_value(exu_op_e o, logic ui, logic [31:0] a,
                                              logic [31:0] b, logic [31:0] i, logic [31:0] p);
        logic [31:0] y;
        y = ui ? i : b;
        case (o)
            OP_ADD:          return a + y;
            OP_SUB:          return a - y;
            OP_AND:          return a & y;
            OP_OR:           return a | y;
            OP_XOR:          return a ^ y;
            OP_SLL:          return a << y[4:0];
            OP_SRL:          return a >> y[4:0];
            OP_SRA:          return $signed(a) >>> y[4:0];
            OP_SLT:          return ($signed(a) < $signed(y)) ? 32'd1 : 32'd0;
            OP_SLTU:         return (a < y) ? 32'd1 : 32'd0;
            OP_LUI:          return i;
            OP_AUIPC:        return p + i;
            OP_JAL, OP_JALR: return p + 32'd4;
            default:         return 32'd0;
        endcase
    endfunction

    function automatic logic branch_taken(exu_op_e o, logic [31:0] a, logic [31:0] b);
        case (o)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return $signed(a) >= $signed(b);
            OP_BLTU: return a < b;
            OP_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] next_pc(exu_op_e o, logic [31:0] a, logic [31:0] b,
                                            logic [31:0] i, logic [31:0] p);
        if (o == OP_JALR) begin
            return (a + i) & ~32'd1;
        end
        if (o == OP_JAL || branch_taken(o, a, b)) begin
            return p + i;
        end
        return p + 32'd4;
    endfunction

    // one strobe bit for every byte lane the access covers
    function automatic logic [3:0] lane_strobe(exu_op_e o, logic [1:0] lo);
        logic [3:0] s;
        for (int k = 0; k < 4; k++) begin
            case (op_size(o))
                SZ_BYTE: s[k] = (k == lo);
                SZ_HALF: s[k] = ((k / 2) == lo[1]);
                default: s[k] = 1'b1;
            endcase
        end
        return s;
    endfunction

    // store data repeated over every lane it may land in
    function automatic logic [31:0] store_lanes(exu_op_e o, logic [31:0] b);
        case (op_size(o))
            SZ_BYTE: return {4{b[7:0]}};
            SZ_HALF: return {2{b[15:0]}};
            default: return b;
        endcase
    endfunction

    function automatic logic [31:0] load_extend(exu_op_e o, logic [31:0] w, logic [1:0] lo);
        logic [7:0]  bt;
        logic [15:0] hw;
        bt = w[8*lo +: 8];
        hw = lo[1] ? w[31:16] : w[15:0];
        case (o)
            OP_LB:   return {{24{bt[7]}}, bt};
            OP_LBU:  return {24'd0, bt};
            OP_LH:   return {{16{hw[15]}}, hw};
            OP_LHU:  return {16'd0, hw};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] rand_addr(exu_op_e o);
        logic [31:0] r;
        r = $urandom;
        case (op_size(o))
            SZ_BYTE: return r;
            SZ_HALF: return {r[31:1], 1'b0};
            default: return {r[31:2], 2'b00};
        endcase
    endfunction

    // ------------------------------
    // drivers and checkers
    // ------------------------------
    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int fails_before);
        $display("test %-8s done, %0d errors", name, fail_cnt - fails_before);
    endtask

    // drive one request, wait for ready, capture the first access cycle
    task automatic run_op(input exu_op_e o, input logic ui, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] i, input logic [31:0] p);
        op       = o;
        use_imm  = ui;
        rs1_d    = a;
        rs2_d    = b;
        imm      = i;
        pc       = p;
        valid    = 1'b1;
        lat      = 0;
        acc_seen = 1'b0;
        do begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            if (psel && penable && !acc_seen) begin
                acc_seen  = 1'b1;
                acc_addr  = paddr;
                acc_write = pwrite;
                acc_strb  = pstrb;
                acc_wdata = pwdata;
            end
        end while (!ready);
        res_rd   = rd_d;
        res_dnpc = dnpc;
        res_err  = err;
        @(posedge clk);
        #10;
        valid = 1'b0;
    endtask

    task automatic mem_access(input exu_op_e o, input logic [31:0] addr, input logic stalled);
        logic [31:0] i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        logic [31:0] word;
        logic [31:0] mask;
        logic [3:0]  strb;
        logic [1:0]  w;
        i        = sext12($urandom);
        a        = addr - i;
        b        = $urandom;
        p        = $urandom & 32'hffff_fffc;
        word     = shadow[addr[9:2]];
        strb     = lane_strobe(o, addr[1:0]);
        mask     = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        w        = 2'($urandom_range(0, 3));
        wait_cnt = w;
        stall    = stalled;
        run_op(o, 1'b0, a, b, i, p);
        stall = 1'b0;
        compare("dnpc", res_dnpc, p + 32'd4);
        compare("err", res_err, stalled);
        if (stalled || is_store(o)) begin
            compare("rd_d", res_rd, 32'd0);
        end else begin
            compare("rd_d", res_rd, load_extend(o, word, addr[1:0]));
        end
        if (!stalled) begin
            compare("latency", lat, 3 + w);
            if (!acc_seen) begin
                $display("access to %h never reached the APB access phase", addr);
                fail_cnt++;
            end
            compare("paddr", acc_addr, {addr[31:2], 2'b00});
            compare("pwrite", acc_write, is_store(o));
        end
        if (is_store(o) && !stalled) begin
            compare("pstrb", acc_strb, strb);
            compare("pwdata", acc_wdata & mask, store_lanes(o, b) & mask);
            shadow[addr[9:2]] = (word & ~mask) | (store_lanes(o, b) & mask);
        end
    endtask

    task automatic check_memory();
        for (int k = 0; k < 256; k++) begin
            compare($sformatf("mem[%0d]", k), mem0.mem[k], shadow[k]);
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        exu_op_e     o;
        logic        ui;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] i;
        logic [31:0] p;
        int          f0;
        exu_op_e     st_ops[3];
        exu_op_e     ld_ops[5];

        void'($urandom(32'h8347_514d));
        st_ops   = '{OP_SB, OP_SH, OP_SW};
        ld_ops   = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
        pass_cnt = 0;
        fail_cnt = 0;
        rst_n    = 1'b0;
        valid    = 1'b0;
        op       = OP_ADD;
        use_imm  = 1'b0;
        rs1_d    = 32'd0;
        rs2_d    = 32'd0;
        imm      = 32'd0;
        pc       = 32'd0;
        wait_cnt = 2'd0;
        stall    = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;

        f0 = fail_cnt;
        @(negedge clk);
        compare("psel", psel, 1'b0);
        compare("penable", penable, 1'b0);
        compare("ready", ready, 1'b0);
        for (int k = 0; k < 256; k++) begin
            shadow[k] = mem0.mem[k];
        end
        @(posedge clk);
        #10;
        finish_test("reset", f0);

        f0 = fail_cnt;
        repeat (200) begin
            o  = exu_op_e'($urandom_range(0, 11));
            ui = 1'($urandom_range(0, 1));
            a  = $urandom;
            b  = $urandom;
            i  = (o == OP_LUI || o == OP_AUIPC) ? ($urandom & 32'hffff_f000) : sext12($urandom);
            p  = $urandom & 32'hffff_fffc;
            run_op(o, ui, a, b, i, p);
            compare("rd_d", res_rd, alu_value(o, ui, a, b, i, p));
            compare("dnpc", res_dnpc, p + 32'd4);
            compare("err", res_err, 1'b0);
            compare("latency", lat, 1);
        end
        finish_test("alu", f0);

        f0 = fail_cnt;
        repeat (150) begin
            o = exu_op_e'($urandom_range(12, 19));
            a = $urandom;
            // equal operands now and then so beq and bge see ties
            b = ($urandom_range(0, 3) == 0) ? a : $urandom;
            i = sext12($urandom);
            p = $urandom & 32'hffff_fffc;
            run_op(o, 1'b0, a, b, i, p);
            compare("rd_d", res_rd, alu_value(o, 1'b0, a, b, i, p));
            compare("dnpc", res_dnpc, next_pc(o, a, b, i, p));
            compare("latency", lat, 1);
        end
        finish_test("flow", f0);

        f0 = fail_cnt;
        foreach (st_ops[s]) begin
            repeat (150) begin
                mem_access(st_ops[s], rand_addr(st_ops[s]), 1'b0);
            end
        end
        check_memory();
        finish_test("store", f0);

        f0 = fail_cnt;
        foreach (ld_ops[s]) begin
            repeat (150) begin
                mem_access(ld_ops[s], rand_addr(ld_ops[s]), 1'b0);
            end
        end
        finish_test("load", f0);

        f0 = fail_cnt;
        repeat (10) begin
            o = exu_op_e'($urandom_range(20, 27));
            mem_access(o, rand_addr(o), 1'b1);
        end
        // normal traffic after the aborts
        mem_access(OP_LW, rand_addr(OP_LW), 1'b0);
        check_memory();
        finish_test("timeout", f0);

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
